/* lsu_settings.svh */
// Bus and pipeline width macros for the load/store unit, included by the package and RTL
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

//////////////////////////////
// Data bus geometry
//////////////////////////////

// Byte address width
`define LSU_ADDR_W 32

// Bus and register word width
`define LSU_DATA_W 32

// One enable per byte lane
`define LSU_BE_W 4

//////////////////////////////
// Transaction tracking
//////////////////////////////

// Granted requests allowed to wait for rvalid
`define LSU_MAX_OUTSTANDING 2

`endif

/* lsu_pkg.sv */
// Shared types of the load/store unit, imported by every RTL block and the testbench
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  // Byte address on the data bus
  typedef logic [`LSU_ADDR_W-1:0] addr_t;

  // Bus or register data word
  typedef logic [`LSU_DATA_W-1:0] data_t;

  // Byte lane enables
  typedef logic [`LSU_BE_W-1:0] be_t;

  // Access size code
  typedef logic [1:0] lsu_size_t;

  // Byte position inside a word
  typedef logic [1:0] byte_off_t;

  // Outstanding transaction count
  typedef logic [1:0] out_cnt_t;

  // Size encodings driven by the core
  localparam lsu_size_t LSU_SIZE_BYTE = 2'd0;
  localparam lsu_size_t LSU_SIZE_HALF = 2'd1;
  localparam lsu_size_t LSU_SIZE_WORD = 2'd2;

  //////////////////////////////
  // Split access FSM
  //////////////////////////////

  typedef enum logic {
    SPLIT_FIRST,
    SPLIT_SECOND
  } split_phase_e;

endpackage

`default_nettype wire

/* lsu_request_gen.sv */
// EX stage of the load/store unit: address, split detection, byte enables and store lanes
`default_nettype none

`include "lsu_settings.svh"

module lsu_request_gen (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              lsu_valid_i,
  input  logic              lsu_we_i,
  input  lsu_pkg::lsu_size_t lsu_size_i,
  input  lsu_pkg::addr_t    operand_a_i,
  input  lsu_pkg::addr_t    operand_b_i,
  input  lsu_pkg::data_t    wdata_i,
  input  logic              ex_update_i,
  input  logic              bus_gnt_i,
  output lsu_pkg::addr_t    req_addr_o,
  output lsu_pkg::be_t      req_be_o,
  output lsu_pkg::data_t    req_wdata_o,
  output logic              split_first_o,
  output logic              split_second_o,
  output lsu_pkg::addr_t    last_addr_o
);
  import lsu_pkg::*;

  // Current phase of a possibly split access
  split_phase_e phase_q;
  // Raw sum of base and offset operands
  addr_t        addr_sum;
  byte_off_t    offset;
  data_t        wdata_rot;

  assign split_second_o = (phase_q == SPLIT_SECOND);

  //////////////////////////////
  // Address generation
  //////////////////////////////

  // Second phase targets the next word
  assign addr_sum = operand_a_i + operand_b_i + (split_second_o ? addr_t'(4) : addr_t'(0));
  // Low bits unchanged by the +4
  assign offset   = addr_sum[1:0];

  // Second phase is always word aligned
  assign req_addr_o = split_second_o ? {addr_sum[`LSU_ADDR_W-1:2], 2'b00} : addr_sum;

  // Split needed for unaligned word or halfword crossing the word
  always_comb
  begin
    split_first_o = 1'b0;
    if (lsu_valid_i && !split_second_o)
    begin
      case (lsu_size_i)
        LSU_SIZE_WORD: split_first_o = (offset != 2'd0);
        LSU_SIZE_HALF: split_first_o = (offset == 2'd3);
        default:       split_first_o = 1'b0;
      endcase
    end
  end

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  always_comb
  begin
    case (lsu_size_i)
      LSU_SIZE_BYTE:
      begin
        req_be_o = be_t'(4'b0001 << offset);
      end
      LSU_SIZE_HALF:
      begin
        // Upper byte of an offset-3 halfword lands in lane 0 of next word
        if (split_second_o)
          req_be_o = 4'b0001;
        else
          req_be_o = be_t'(4'b0011 << offset);
      end
      default:
      begin
        // First phase from the offset upward, second phase below it
        if (split_second_o)
          req_be_o = ~be_t'(4'b1111 << offset);
        else
          req_be_o = be_t'(4'b1111 << offset);
      end
    endcase
  end

  //////////////////////////////
  // Store data lanes
  //////////////////////////////

  // Rotate left by offset bytes
  always_comb
  begin
    case (offset)
      2'd0:    wdata_rot = wdata_i;
      2'd1:    wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_rot = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  // Quiet write lanes during loads
  assign req_wdata_o = lsu_we_i ? wdata_rot : '0;

  //////////////////////////////
  // Phase and address state
  //////////////////////////////

  // Back to first phase once EX empties or the access completes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      phase_q <= SPLIT_FIRST;
    else if (!lsu_valid_i)
      phase_q <= SPLIT_FIRST;
    else if (ex_update_i)
      phase_q <= split_first_o ? SPLIT_SECOND : SPLIT_FIRST;
  end

  // Address of the most recent grant, kept for error reporting
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      last_addr_o <= '0;
    else if (lsu_valid_i && bus_gnt_i)
      last_addr_o <= req_addr_o;
  end

endmodule

`default_nettype wire

/* lsu_outstanding_ctrl.sv */
// Outstanding transaction tracking and EX/WB handshake for the load/store unit
`default_nettype none

`include "lsu_settings.svh"

module lsu_outstanding_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic lsu_valid_i,
  input  logic bus_gnt_i,
  input  logic bus_rvalid_i,
  input  logic split_first_i,
  output logic bus_req_o,
  output logic ex_update_o,
  output logic lsu_ready_o,
  output logic busy_o
);
  import lsu_pkg::*;

  // Granted but not yet answered
  out_cnt_t cnt_q;
  out_cnt_t cnt_d;
  logic     count_up;
  logic     count_down;
  // Address phase in EX finished
  logic     ex_done;

  //////////////////////////////
  // Request qualification
  //////////////////////////////

  // No combinational path from rvalid to req
  assign bus_req_o = lsu_valid_i && (cnt_q < out_cnt_t'(`LSU_MAX_OUTSTANDING));

  assign count_up   = bus_req_o && bus_gnt_i;
  assign count_down = bus_rvalid_i;

  //////////////////////////////
  // EX/WB lock step
  //////////////////////////////

  // Empty WB takes the grant alone
  // Full WB also needs its response in the same cycle
  // At the limit the EX phase was granted already and waits for rvalid
  always_comb
  begin
    case (cnt_q)
      2'd0:    ex_done = bus_req_o && bus_gnt_i;
      2'd1:    ex_done = bus_req_o && bus_gnt_i && bus_rvalid_i;
      default: ex_done = bus_rvalid_i;
    endcase
  end

  assign ex_update_o = lsu_valid_i && ex_done;

  // Hold the core while the second phase still has to run
  assign lsu_ready_o = ex_update_o && !split_first_i;

  assign busy_o = (cnt_q != '0) || bus_req_o;

  //////////////////////////////
  // Counter
  //////////////////////////////

  // Up and down together leave it unchanged
  always_comb
  begin
    cnt_d = cnt_q;
    if (count_up && !count_down)
      cnt_d = cnt_q + out_cnt_t'(1);
    else if (!count_up && count_down)
      cnt_d = cnt_q - out_cnt_t'(1);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

endmodule

`default_nettype wire

/* lsu_rdata_align.sv */
// WB stage of the load/store unit: split read assembly, extension and result flags
`default_nettype none

module lsu_rdata_align (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ex_update_i,
  input  logic               lsu_we_i,
  input  lsu_pkg::lsu_size_t lsu_size_i,
  input  logic               lsu_sign_ext_i,
  input  lsu_pkg::byte_off_t req_offset_i,
  input  logic               split_first_i,
  input  logic               split_second_i,
  input  logic               bus_rvalid_i,
  input  logic               bus_err_i,
  input  lsu_pkg::data_t     bus_rdata_i,
  output logic               result_valid_o,
  output logic               result_err_o,
  output lsu_pkg::data_t     result_rdata_o
);
  import lsu_pkg::*;

  // WB copies of the EX control
  lsu_size_t size_q;
  logic      sign_q;
  logic      we_q;
  byte_off_t offset_q;
  // Low while a split first phase waits for its response
  logic      last_q;
  // First-phase read word of a split load
  data_t     rdata_q;

  data_t     rdata_w;
  data_t     rdata_h;
  data_t     rdata_b;

  //////////////////////////////
  // WB control registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q   <= LSU_SIZE_WORD;
      sign_q   <= 1'b0;
      we_q     <= 1'b0;
      offset_q <= '0;
      last_q   <= 1'b1;
    end
    else if (ex_update_i)
    begin
      size_q <= lsu_size_i;
      sign_q <= lsu_sign_ext_i;
      we_q   <= lsu_we_i;
      last_q <= !split_first_i;
      // Second phase address is aligned, keep the original offset
      if (!split_second_i)
        offset_q <= req_offset_i;
    end
  end

  // Low part of a split load
  always_ff @(posedge clk)
  begin
    if (bus_rvalid_i && !last_q && !we_q)
      rdata_q <= bus_rdata_i;
  end

  //////////////////////////////
  // Lane selection
  //////////////////////////////

  // Words, joined with the first phase when unaligned
  always_comb
  begin
    case (offset_q)
      2'd0:    rdata_w = bus_rdata_i;
      2'd1:    rdata_w = {bus_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w = {bus_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {bus_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // Halfwords, offset 3 spans both phases
  always_comb
  begin
    logic [15:0] half;
    case (offset_q)
      2'd0:    half = bus_rdata_i[15:0];
      2'd1:    half = bus_rdata_i[23:8];
      2'd2:    half = bus_rdata_i[31:16];
      default: half = {bus_rdata_i[7:0], rdata_q[31:24]};
    endcase
    rdata_h = {{16{sign_q && half[15]}}, half};
  end

  // Bytes
  always_comb
  begin
    logic [7:0] byte_sel;
    case (offset_q)
      2'd0:    byte_sel = bus_rdata_i[7:0];
      2'd1:    byte_sel = bus_rdata_i[15:8];
      2'd2:    byte_sel = bus_rdata_i[23:16];
      default: byte_sel = bus_rdata_i[31:24];
    endcase
    rdata_b = {{24{sign_q && byte_sel[7]}}, byte_sel};
  end

  always_comb
  begin
    case (size_q)
      LSU_SIZE_BYTE: result_rdata_o = rdata_b;
      LSU_SIZE_HALF: result_rdata_o = rdata_h;
      default:       result_rdata_o = rdata_w;
    endcase
  end

  //////////////////////////////
  // Result flags
  //////////////////////////////

  // Only the final phase completes the access
  assign result_valid_o = bus_rvalid_i && last_q;
  assign result_err_o   = bus_rvalid_i && bus_err_i;

endmodule

`default_nettype wire

/* lsu_top.sv */
// Load/store unit top level joining the EX, tracking and WB blocks to the core and data bus
`default_nettype none

module lsu_top (
  input  logic               clk,
  input  logic               rst_n,
  // Core side, held until lsu_ready_o
  input  logic               lsu_valid_i,
  input  logic               lsu_we_i,
  input  lsu_pkg::lsu_size_t lsu_size_i,
  input  logic               lsu_sign_ext_i,
  input  lsu_pkg::addr_t     operand_a_i,
  input  lsu_pkg::addr_t     operand_b_i,
  input  lsu_pkg::data_t     wdata_i,
  output logic               lsu_ready_o,
  output logic               lsu_split_o,
  output logic               result_valid_o,
  output lsu_pkg::data_t     result_rdata_o,
  output logic               result_err_o,
  output lsu_pkg::addr_t     last_addr_o,
  output logic               busy_o,
  // Data bus
  output logic               data_req_o,
  output lsu_pkg::addr_t     data_addr_o,
  output logic               data_we_o,
  output lsu_pkg::be_t       data_be_o,
  output lsu_pkg::data_t     data_wdata_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  lsu_pkg::data_t     data_rdata_i,
  input  logic               data_err_i
);

  // Stage linkage
  logic split_first;
  logic split_second;
  logic ex_update;

  assign lsu_split_o = split_first;
  assign data_we_o   = lsu_we_i;

  //////////////////////////////
  // EX stage
  //////////////////////////////

  lsu_request_gen u_request_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .lsu_valid_i    (lsu_valid_i),
    .lsu_we_i       (lsu_we_i),
    .lsu_size_i     (lsu_size_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .wdata_i        (wdata_i),
    .ex_update_i    (ex_update),
    .bus_gnt_i      (data_gnt_i),
    .req_addr_o     (data_addr_o),
    .req_be_o       (data_be_o),
    .req_wdata_o    (data_wdata_o),
    .split_first_o  (split_first),
    .split_second_o (split_second),
    .last_addr_o    (last_addr_o)
  );

  // Request gating and lock step advance
  lsu_outstanding_ctrl u_outstanding_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_valid_i   (lsu_valid_i),
    .bus_gnt_i     (data_gnt_i),
    .bus_rvalid_i  (data_rvalid_i),
    .split_first_i (split_first),
    .bus_req_o     (data_req_o),
    .ex_update_o   (ex_update),
    .lsu_ready_o   (lsu_ready_o),
    .busy_o        (busy_o)
  );

  //////////////////////////////
  // WB stage
  //////////////////////////////

  lsu_rdata_align u_rdata_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_update_i    (ex_update),
    .lsu_we_i       (lsu_we_i),
    .lsu_size_i     (lsu_size_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .req_offset_i   (data_addr_o[1:0]),
    .split_first_i  (split_first),
    .split_second_i (split_second),
    .bus_rvalid_i   (data_rvalid_i),
    .bus_err_i      (data_err_i),
    .bus_rdata_i    (data_rdata_i),
    .result_valid_o (result_valid_o),
    .result_err_o   (result_err_o),
    .result_rdata_o (result_rdata_o)
  );

endmodule

`default_nettype wire

/* lsu_properties.sv */
// Bus protocol and control rules of the load/store unit, bound to lsu_top by the testbench
`default_nettype none

module lsu_properties (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           data_req_o,
  input  lsu_pkg::addr_t data_addr_o,
  input  logic           data_we_o,
  input  lsu_pkg::be_t   data_be_o,
  input  lsu_pkg::data_t data_wdata_o,
  input  logic           data_gnt_i,
  input  logic           data_rvalid_i,
  input  logic           busy_o,
  input  logic           lsu_split_o,
  input  logic           result_valid_o,
  input  logic           result_err_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed checks, watched by the testbench
  int         fail_count = 0;
  // Granted requests still waiting for rvalid
  logic [2:0] out_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_cnt <= '0;
    else
      out_cnt <= out_cnt + {2'b00, data_req_o && data_gnt_i} - {2'b00, data_rvalid_i};
  end

  //////////////////////////////
  // Bus protocol
  //////////////////////////////

  // Request held with stable fields until granted
  req_held_a: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) && $stable(data_be_o)
      && $stable(data_wdata_o) && $stable(data_we_o))
    else
    begin
      fail_count++;
      $error("bus request dropped or changed before its grant");
    end

  // Never more than two in flight
  count_limit_a: assert property (@(posedge clk) disable iff (!rst_n) out_cnt <= 3'd2)
    else
    begin
      fail_count++;
      $error("more than two outstanding transactions");
    end

  //////////////////////////////
  // Control outputs
  //////////////////////////////

  // Busy exactly while a request or a response is pending
  busy_match_a: assert property (@(posedge clk) disable iff (!rst_n)
    busy_o == (out_cnt != 3'd0 || data_req_o))
    else
    begin
      fail_count++;
      $error("busy does not match the pending requests and responses");
    end

  // Quiet outputs while reset is held
  reset_quiet_a: assert property (@(posedge clk)
    !rst_n |-> !data_req_o && !lsu_split_o && !result_valid_o && !result_err_o && !busy_o)
    else
    begin
      fail_count++;
      $error("control output high during reset");
    end

endmodule

`default_nettype wire

/* tb_lsu.sv */
// Testbench for the load/store unit with a random-latency bus memory and a reference memory
`default_nettype none

module tb_lsu;
  timeunit 1ns;
  timeprecision 1ps;
  import lsu_pkg::*;

  localparam int    NUM_RANDOM     = 24;
  // Directed accesses plus the random ones
  localparam int    NUM_ACCESSES   = 30 + NUM_RANDOM;
  localparam int    TIMEOUT_CYCLES = 40 * NUM_ACCESSES;
  localparam addr_t BASE_ADDR      = 32'h1000_0000;

  logic      clk;
  logic      rst_n;
  logic      lsu_valid_i;
  logic      lsu_we_i;
  lsu_size_t lsu_size_i;
  logic      lsu_sign_ext_i;
  addr_t     operand_a_i;
  addr_t     operand_b_i;
  data_t     wdata_i;
  logic      lsu_ready_o;
  logic      lsu_split_o;
  logic      result_valid_o;
  data_t     result_rdata_o;
  logic      result_err_o;
  addr_t     last_addr_o;
  logic      busy_o;
  logic      data_req_o;
  addr_t     data_addr_o;
  logic      data_we_o;
  be_t       data_be_o;
  data_t     data_wdata_o;
  logic      data_gnt_i;
  logic      data_rvalid_i;
  data_t     data_rdata_i;
  logic      data_err_i;

  // Reference and bus copies of the 64-byte memory
  logic [7:0] ref_mem [64];
  logic [7:0] bus_mem [64];
  integer     seed;
  int         cycle_cnt;
  int         model_cycle;
  // Address of the final bus phase of the latest access
  addr_t      exp_last_addr;

  // Expected results in issue order
  data_t exp_data_q [$];
  logic  exp_err_q [$];
  logic  exp_chk_q [$];
  string exp_name_q [$];

  // Responses waiting in the bus model
  data_t resp_data_q [$];
  logic  resp_err_q [$];
  int    resp_due_q [$];

  // Access now in EX, written with non-blocking assignments
  logic      cur_valid;
  logic      cur_split;
  logic      cur_err;
  addr_t     cur_addr;
  lsu_size_t cur_size;
  string     cur_name;
  int        phase_cnt;

  lsu_top uut (.*);

  bind lsu_top lsu_properties props (.*);

  always #4 clk = ~clk;

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic stop_failed();
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(string name, data_t exp, data_t act);
    $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
    stop_failed();
  endtask

  task automatic report_error(string msg);
    $display("ERROR %s", msg);
    stop_failed();
  endtask

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  function automatic int size_bytes(lsu_size_t size);
    return (size == LSU_SIZE_BYTE) ? 1 : (size == LSU_SIZE_HALF) ? 2 : 4;
  endfunction

  // Little-endian read with wrap at the end of the memory
  function automatic data_t load_ref(addr_t addr, lsu_size_t size, logic sign);
    data_t v;
    int    i;
    v = '0;
    for (i = 0; i < size_bytes(size); i++)
      v[8*i +: 8] = ref_mem[(addr + addr_t'(i)) & addr_t'(63)];
    if (sign && size == LSU_SIZE_BYTE)
      v[31:8] = {24{v[7]}};
    if (sign && size == LSU_SIZE_HALF)
      v[31:16] = {16{v[15]}};
    return v;
  endfunction

  // Last byte beyond the end of the word
  function automatic logic crosses_word(addr_t addr, lsu_size_t size);
    return (int'(addr[1:0]) + size_bytes(size)) > 4;
  endfunction

  // Lanes of the bytes that fall in the first word or in the next one
  function automatic be_t lane_enables(addr_t addr, lsu_size_t size, logic second);
    be_t        be;
    int         i;
    logic [2:0] pos;
    be = '0;
    for (i = 0; i < size_bytes(size); i++)
    begin
      pos = 3'(addr[1:0]) + 3'(i);
      if (pos[2] == second)
        be[pos[1:0]] = 1'b1;
    end
    return be;
  endfunction

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // Called on a rising edge, returns on the edge where lsu_ready_o was seen
  task automatic access(string name, logic we, lsu_size_t size, logic sign, addr_t a,
                        addr_t b, data_t wd, logic err);
    addr_t addr;
    int    i;
    addr = a + b;
    exp_err_q.push_back(err);
    exp_name_q.push_back(name);
    exp_chk_q.push_back(!we);
    if (we)
    begin
      exp_data_q.push_back('0);
      for (i = 0; i < size_bytes(size); i++)
        ref_mem[(addr + addr_t'(i)) & addr_t'(63)] = wd[8*i +: 8];
    end
    else
      exp_data_q.push_back(load_ref(addr, size, sign));
    exp_last_addr = crosses_word(addr, size) ? {addr[31:2], 2'b00} + addr_t'(4) : addr;
    lsu_valid_i    <= 1'b1;
    lsu_we_i       <= we;
    lsu_size_i     <= size;
    lsu_sign_ext_i <= sign;
    operand_a_i    <= a;
    operand_b_i    <= b;
    wdata_i        <= wd;
    cur_valid      <= 1'b1;
    cur_split      <= crosses_word(addr, size);
    cur_addr       <= addr;
    cur_size       <= size;
    cur_err        <= err;
    cur_name       <= name;
    do
      @(posedge clk);
    while (!lsu_ready_o);
  endtask

  // Drain every response and check the captured address
  task automatic wait_idle(addr_t exp_last);
    lsu_valid_i <= 1'b0;
    cur_valid   <= 1'b0;
    do
      @(posedge clk);
    while (busy_o || data_rvalid_i || resp_due_q.size() != 0);
    if (exp_data_q.size() != 0)
      report_error("results missing after the bus went idle");
    if (last_addr_o !== exp_last)
      report_mismatch("last address", exp_last, last_addr_o);
  endtask

  //////////////////////////////
  // Bus memory model
  //////////////////////////////

  always @(posedge clk)
  begin : bus_model
    int    r;
    int    l;
    addr_t base;
    data_t rd;
    if (rst_n)
    begin
      // Grant stalls about one cycle in four
      data_gnt_i <= ({$random(seed)} % 4) != 0;
      if (data_req_o && data_gnt_i)
      begin
        base = {data_addr_o[31:2], 2'b00};
        for (l = 0; l < 4; l++)
        begin
          if (data_we_o && data_be_o[l])
            bus_mem[(base + addr_t'(l)) & addr_t'(63)] = data_wdata_o[8*l +: 8];
          rd[8*l +: 8] = bus_mem[(base + addr_t'(l)) & addr_t'(63)];
        end
        r = {$random(seed)} % 3;
        resp_data_q.push_back(rd);
        resp_err_q.push_back(cur_err);
        resp_due_q.push_back(model_cycle + r);
      end
      // In order, 1 to 3 cycles after the grant
      if (resp_due_q.size() != 0 && resp_due_q[0] <= model_cycle)
      begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= resp_data_q.pop_front();
        data_err_i    <= resp_err_q.pop_front();
        void'(resp_due_q.pop_front());
      end
      else
      begin
        data_rvalid_i <= 1'b0;
        data_err_i    <= 1'b0;
      end
      model_cycle++;
    end
  end

  //////////////////////////////
  // Grant and result checks
  //////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n && cur_valid && data_req_o && data_gnt_i)
    begin
      if (phase_cnt == 0)
      begin
        if (data_addr_o !== cur_addr)
          report_mismatch({cur_name, " address"}, cur_addr, data_addr_o);
        if (data_be_o !== lane_enables(cur_addr, cur_size, 1'b0))
          report_mismatch({cur_name, " enables"}, lane_enables(cur_addr, cur_size, 1'b0),
                          data_be_o);
        if (lsu_split_o !== cur_split)
          report_mismatch({cur_name, " split"}, cur_split, lsu_split_o);
      end
      else if (phase_cnt == 1 && cur_split)
      begin
        // Second phase goes to the next aligned word
        if (data_addr_o !== {cur_addr[31:2], 2'b00} + addr_t'(4))
          report_mismatch({cur_name, " second address"}, {cur_addr[31:2], 2'b00} + 4,
                          data_addr_o);
        if (data_be_o !== lane_enables(cur_addr, cur_size, 1'b1))
          report_mismatch({cur_name, " second enables"},
                          lane_enables(cur_addr, cur_size, 1'b1), data_be_o);
        if (lsu_split_o !== 1'b0)
          report_error("split flag high in the second phase");
      end
      else
        report_error("extra bus grant for one access");
      phase_cnt = phase_cnt + 1;
    end
    if (rst_n && cur_valid && lsu_ready_o)
    begin
      if (phase_cnt != (cur_split ? 2 : 1))
        report_error("wrong number of bus grants for one access");
      phase_cnt = 0;
    end
    if (rst_n && result_valid_o)
    begin
      if (exp_data_q.size() == 0)
        report_error("result without an issued access");
      if (exp_chk_q[0] && result_rdata_o !== exp_data_q[0])
        report_mismatch(exp_name_q[0], exp_data_q[0], result_rdata_o);
      if (result_err_o !== exp_err_q[0])
        report_mismatch({exp_name_q[0], " error"}, exp_err_q[0], result_err_o);
      void'(exp_data_q.pop_front());
      void'(exp_err_q.pop_front());
      void'(exp_chk_q.pop_front());
      void'(exp_name_q.pop_front());
    end
    else if (rst_n && result_err_o)
      report_error("error flag without a result");
  end

  // Timeout and bound assertion watch
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_error("timeout waiting for the load/store unit");
    if (uut.props.fail_count != 0)
      report_error("bound assertion failed");
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin : stimulus
    int s;
    int off;
    int k;
    clk = 1'b0;
    rst_n = 1'b0;
    lsu_valid_i = 1'b0;
    lsu_we_i = 1'b0;
    lsu_size_i = LSU_SIZE_WORD;
    lsu_sign_ext_i = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    wdata_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    data_err_i = 1'b0;
    cur_valid = 1'b0;
    cur_split = 1'b0;
    cur_err = 1'b0;
    cur_addr = '0;
    cur_size = LSU_SIZE_WORD;
    phase_cnt = 0;
    cycle_cnt = 0;
    model_cycle = 0;
    exp_last_addr = '0;
    seed = 32'h6441_6101;
    for (k = 0; k < 64; k++)
    begin
      ref_mem[k] = 8'(k * 37 + 129);
      bus_mem[k] = 8'(k * 37 + 129);
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Aligned word round trip
    access("word store", 1, LSU_SIZE_WORD, 0, BASE_ADDR, 8, 32'hCAFE_F00D, 0);
    access("word load", 0, LSU_SIZE_WORD, 0, BASE_ADDR, 8, 0, 0);
    // Bytes and halfwords, zero then sign extended
    for (s = 0; s < 2; s++)
    begin
      for (off = 0; off < 4; off++)
        access("byte load", 0, LSU_SIZE_BYTE, 1'(s), BASE_ADDR, 16 + off, 0, 0);
      for (off = 0; off < 3; off++)
        access("half load", 0, LSU_SIZE_HALF, 1'(s), BASE_ADDR, 16 + off, 0, 0);
    end
    // Accesses crossing a word boundary
    for (off = 1; off < 4; off++)
      access("split word load", 0, LSU_SIZE_WORD, 0, BASE_ADDR, 32 + off, 0, 0);
    access("split word store", 1, LSU_SIZE_WORD, 0, BASE_ADDR, 45, 32'h1234_5678, 0);
    access("split word reload", 0, LSU_SIZE_WORD, 0, BASE_ADDR, 45, 0, 0);
    access("split half load", 0, LSU_SIZE_HALF, 1, BASE_ADDR, 51, 0, 0);
    access("split half store", 1, LSU_SIZE_HALF, 0, BASE_ADDR, 55, 32'h0000_BEEF, 0);
    access("split half reload", 0, LSU_SIZE_HALF, 0, BASE_ADDR, 55, 0, 0);
    access("wrapping word load", 0, LSU_SIZE_WORD, 0, BASE_ADDR, 63, 0, 0);
    // Partial stores seen through word loads
    access("byte store", 1, LSU_SIZE_BYTE, 0, BASE_ADDR, 21, 32'h0000_005A, 0);
    access("half store", 1, LSU_SIZE_HALF, 0, BASE_ADDR, 26, 32'h0000_A55A, 0);
    access("byte store check", 0, LSU_SIZE_WORD, 0, BASE_ADDR, 20, 0, 0);
    access("half store check", 0, LSU_SIZE_WORD, 0, BASE_ADDR, 24, 0, 0);
    wait_idle(BASE_ADDR + 24);
    // Bus error response
    @(posedge clk);
    access("error load", 0, LSU_SIZE_WORD, 0, BASE_ADDR, 12, 0, 1);
    wait_idle(BASE_ADDR + 12);
    // Back-to-back random traffic
    @(posedge clk);
    for (k = 0; k < NUM_RANDOM; k++)
      access("random access", 1'($random(seed)), lsu_size_t'({$random(seed)} % 3),
             1'($random(seed)), BASE_ADDR, addr_t'({$random(seed)} % 64), $random(seed), 0);
    wait_idle(exp_last_addr);

    if (uut.props.fail_count == 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
      stop_failed();
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
lsu_pkg.sv
lsu_request_gen.sv
lsu_outstanding_ctrl.sv
lsu_rdata_align.sv
lsu_top.sv
lsu_properties.sv
tb_lsu.sv
